// ==== hdl/core_pkg.sv ====
// ----------------------------------------------------------
// shared widths, encodings and stage payloads of the core
// referenced by scoped names from every RTL file
// ----------------------------------------------------------
`default_nettype none

package core_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int PC_W       = 8;
    localparam int EXC_W      = 3;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;

    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;
    localparam logic [5:0] FN_SLL = 6'h00;
    localparam logic [5:0] FN_SRL = 6'h02;

    localparam logic [EXC_W-1:0] EXC_NONE       = 3'd0;
    localparam logic [EXC_W-1:0] EXC_UNDEFINED  = 3'd1; // raised in decode
    localparam logic [EXC_W-1:0] EXC_OVERFLOW   = 3'd2; // raised in execute
    localparam logic [EXC_W-1:0] EXC_ZERO_WRITE = 3'd7; // raised in result

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_t;

    typedef struct packed {
        logic                  valid;
        logic [PC_W-1:0]       pc;
        alu_op_t               alu_op;
        logic                  use_imm;    // addi takes the immediate as b
        logic                  writes_reg;
        logic [REG_ADDR_W-1:0] dest;
        logic [DATA_W-1:0]     operand_a;  // already forwarded
        logic [DATA_W-1:0]     operand_b;
        logic [DATA_W-1:0]     immediate;  // sign extended
        logic [4:0]            shamt;
        logic [EXC_W-1:0]      exc;
    } decode_payload_t;

    typedef struct packed {
        logic                  valid;
        logic [PC_W-1:0]       pc;
        logic                  writes_reg;
        logic [REG_ADDR_W-1:0] dest;
        logic [DATA_W-1:0]     result;
        logic [EXC_W-1:0]      exc;
    } execute_payload_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] dest;
        logic [DATA_W-1:0]     data;
    } commit_t;

    typedef struct packed {
        logic             active;
        logic [EXC_W-1:0] code;
        logic [PC_W-1:0]  epc;
    } trap_t;

endpackage

`default_nettype wire

// ==== hdl/register_file.sv ====
// ----------------------------------------------------------
// 32 x 32 register file, two async reads, one clocked write
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire logic                               SYS_clk,
    input  wire logic                               SYS_reset,
    input  wire logic [core_pkg::REG_ADDR_W-1:0]    read_addr_a,
    input  wire logic [core_pkg::REG_ADDR_W-1:0]    read_addr_b,
    output logic      [core_pkg::DATA_W-1:0]        read_data_a,
    output logic      [core_pkg::DATA_W-1:0]        read_data_b,
    input  wire core_pkg::commit_t                  write
);

    logic [core_pkg::DATA_W-1:0] regs [2**core_pkg::REG_ADDR_W];

    always_ff @(posedge SYS_clk)
    begin
        if (write.valid && write.dest != '0)
        begin
            regs[write.dest] <= write.data;
        end
    end

    assign read_data_a = (read_addr_a == '0) ? '0 : regs[read_addr_a]; // r0 is hardwired
    assign read_data_b = (read_addr_b == '0) ? '0 : regs[read_addr_b];

    // result stage turns any r0 write into a fault, so none reaches here
    a_no_r0_commit: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        write.valid |-> write.dest != '0)
        else $error("commit targets register 0");

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
// ----------------------------------------------------------
// integer ALU: add, sub, and, or, slt and the two shifts,
// with signed overflow reported for add and sub
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire core_pkg::alu_op_t               op,
    input  wire logic [core_pkg::DATA_W-1:0]     a,
    input  wire logic [core_pkg::DATA_W-1:0]     b,
    input  wire logic [4:0]                      shamt,
    output logic      [core_pkg::DATA_W-1:0]     result,
    output logic                                 overflow
);

    logic [core_pkg::DATA_W-1:0] sum;
    logic [core_pkg::DATA_W-1:0] diff;

    assign sum  = a + b;
    assign diff = a - b;

    always_comb
    begin
        result   = '0;
        overflow = 1'b0;
        case (op)
            core_pkg::ALU_ADD:
            begin
                result   = sum;
                overflow = (a[31] == b[31]) && (sum[31] != a[31]); // same signs, flipped
            end
            core_pkg::ALU_SUB:
            begin
                result   = diff;
                overflow = (a[31] != b[31]) && (diff[31] != a[31]);
            end
            core_pkg::ALU_AND: result = a & b;
            core_pkg::ALU_OR:  result = a | b;
            core_pkg::ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};
            core_pkg::ALU_SLL: result = b << shamt; // shifts act on rt
            core_pkg::ALU_SRL: result = b >> shamt;
            default:           result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
// ----------------------------------------------------------
// accepts one instruction per strobe, decodes it, reads the
// register file and forwards newer results to execute
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire logic                               SYS_clk,
    input  wire logic                               SYS_reset,
    input  wire logic                               load,
    input  wire logic [core_pkg::PC_W-1:0]          pc_value,
    input  wire logic                               instr_valid,
    input  wire logic [core_pkg::DATA_W-1:0]        instr,
    input  wire logic                               flush,
    input  wire logic                               trap_active,
    output logic      [core_pkg::REG_ADDR_W-1:0]    read_addr_a,
    output logic      [core_pkg::REG_ADDR_W-1:0]    read_addr_b,
    input  wire logic [core_pkg::DATA_W-1:0]        read_data_a,
    input  wire logic [core_pkg::DATA_W-1:0]        read_data_b,
    input  wire core_pkg::execute_payload_t         ex_forward,
    input  wire core_pkg::commit_t                  commit,
    output core_pkg::decode_payload_t               payload
);

    logic [core_pkg::DATA_W-1:0] instr_q;
    logic [core_pkg::PC_W-1:0]   pc_q;    // pc of the held instruction
    logic [core_pkg::PC_W-1:0]   pc_next; // pc given to the next accept
    logic                        valid_q;
    logic                        accept;

    // execute result beats commit, commit beats the register file
    function automatic logic [core_pkg::DATA_W-1:0] forward_operand(
        input logic [core_pkg::REG_ADDR_W-1:0] addr,
        input logic [core_pkg::DATA_W-1:0]     rf_data
    );
        logic [core_pkg::DATA_W-1:0] value;
        value = rf_data;
        if (ex_forward.valid && ex_forward.writes_reg && ex_forward.dest == addr && addr != '0)
            value = ex_forward.result;
        else if (commit.valid && commit.dest == addr)
            value = commit.data;
        return value;
    endfunction

    assign accept = instr_valid && !trap_active && !load && !flush;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            valid_q <= 1'b0;
            instr_q <= '0;
            pc_q    <= '0;
            pc_next <= '0;
        end
        else
        begin
            valid_q <= accept;
            if (load)
            begin
                pc_next <= pc_value;
            end
            else if (accept)
            begin
                instr_q <= instr;
                pc_q    <= pc_next;
                pc_next <= pc_next + 1'b1;
            end
        end
    end

    assign read_addr_a = instr_q[25:21]; // rs
    assign read_addr_b = instr_q[20:16]; // rt

    always_comb
    begin
        payload           = '0;
        payload.valid     = valid_q;
        payload.pc        = pc_q;
        payload.alu_op    = core_pkg::ALU_ADD;
        payload.immediate = {{16{instr_q[15]}}, instr_q[15:0]};
        payload.shamt     = instr_q[10:6];
        payload.operand_a = forward_operand(instr_q[25:21], read_data_a);
        payload.operand_b = forward_operand(instr_q[20:16], read_data_b);
        if (instr_q != '0) // zero word is a bubble
        begin
            case (instr_q[31:26])
                core_pkg::OP_RTYPE:
                begin
                    payload.writes_reg = 1'b1;
                    payload.dest       = instr_q[15:11];
                    case (instr_q[5:0])
                        core_pkg::FN_ADD: payload.alu_op = core_pkg::ALU_ADD;
                        core_pkg::FN_SUB: payload.alu_op = core_pkg::ALU_SUB;
                        core_pkg::FN_AND: payload.alu_op = core_pkg::ALU_AND;
                        core_pkg::FN_OR:  payload.alu_op = core_pkg::ALU_OR;
                        core_pkg::FN_SLT: payload.alu_op = core_pkg::ALU_SLT;
                        core_pkg::FN_SLL: payload.alu_op = core_pkg::ALU_SLL;
                        core_pkg::FN_SRL: payload.alu_op = core_pkg::ALU_SRL;
                        default:          payload.exc    = core_pkg::EXC_UNDEFINED;
                    endcase
                end
                core_pkg::OP_ADDI:
                begin
                    payload.use_imm    = 1'b1;
                    payload.writes_reg = 1'b1;
                    payload.dest       = instr_q[20:16]; // rt for I-type
                end
                default:
                begin
                    payload.exc = core_pkg::EXC_UNDEFINED;
                end
            endcase
            if (payload.exc != core_pkg::EXC_NONE)
                payload.writes_reg = 1'b0;
        end
    end

    // a held trap finds no producer left to forward from
    a_drained_in_trap: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        trap_active |-> !ex_forward.valid && !commit.valid)
        else $error("instruction still in flight while trap active");

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
// ----------------------------------------------------------
// execute stage: registers the decoded op, runs the ALU and
// merges overflow into the fault code carried down the pipe
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire logic                        SYS_clk,
    input  wire logic                        SYS_reset,
    input  wire logic                        flush,
    input  wire core_pkg::decode_payload_t   in_payload,
    output core_pkg::execute_payload_t       out_payload,
    output core_pkg::execute_payload_t       forward
);

    core_pkg::decode_payload_t   q;
    logic [core_pkg::DATA_W-1:0] alu_b;
    logic [core_pkg::DATA_W-1:0] alu_result;
    logic                        overflow;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            q <= '0;
        end
        else
        begin
            q       <= in_payload;
            q.valid <= in_payload.valid && !flush;
        end
    end

    assign alu_b = q.use_imm ? q.immediate : q.operand_b;

    alu u_alu (
        .op       (q.alu_op),
        .a        (q.operand_a),
        .b        (alu_b),
        .shamt    (q.shamt),
        .result   (alu_result),
        .overflow (overflow)
    );

    always_comb
    begin
        forward.valid  = q.valid;
        forward.pc     = q.pc;
        forward.dest   = q.dest;
        forward.result = alu_result;
        if (q.exc != core_pkg::EXC_NONE)
            forward.exc = q.exc; // decode fault stays first
        else if (overflow)
            forward.exc = core_pkg::EXC_OVERFLOW;
        else
            forward.exc = core_pkg::EXC_NONE;
        forward.writes_reg = q.writes_reg && (forward.exc == core_pkg::EXC_NONE);
    end

    // item here is younger than the faulting one in result
    always_comb
    begin
        out_payload       = forward;
        out_payload.valid = forward.valid && !flush;
    end

endmodule

`default_nettype wire

// ==== hdl/result_stage.sv ====
// ----------------------------------------------------------
// result stage: final fault check and register write commit
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  wire logic                        SYS_clk,
    input  wire logic                        SYS_reset,
    input  wire core_pkg::execute_payload_t  in_payload,
    output core_pkg::commit_t                commit,
    output logic [core_pkg::EXC_W-1:0]       fault_code,
    output logic [core_pkg::PC_W-1:0]        fault_pc
);

    core_pkg::execute_payload_t   q;
    logic [core_pkg::EXC_W-1:0]   exc;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            q <= '0;
        else
            q <= in_payload;
    end

    always_comb
    begin
        if (q.exc != core_pkg::EXC_NONE)
            exc = q.exc;
        else if (q.writes_reg && q.dest == '0)
            exc = core_pkg::EXC_ZERO_WRITE; // write to r0
        else
            exc = core_pkg::EXC_NONE;
    end

    always_comb
    begin
        commit.valid = q.valid && q.writes_reg && (exc == core_pkg::EXC_NONE);
        commit.dest  = q.dest;
        commit.data  = q.result;
    end

    assign fault_code = q.valid ? exc : core_pkg::EXC_NONE;
    assign fault_pc   = q.pc;

endmodule

`default_nettype wire

// ==== hdl/exception_unit.sv ====
// ----------------------------------------------------------
// holds the first fault's code and pc until a load clears it
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module exception_unit (
    input  wire logic                           SYS_clk,
    input  wire logic                           SYS_reset,
    input  wire logic                           load,
    input  wire logic [core_pkg::EXC_W-1:0]     fault_code,
    input  wire logic [core_pkg::PC_W-1:0]      fault_pc,
    output logic                                flush,
    output core_pkg::trap_t                     trap
);

    assign flush = (fault_code != core_pkg::EXC_NONE) && !trap.active; // first fault only

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            trap <= '0;
        end
        else if (load)
        begin
            trap <= '0;
        end
        else if (flush)
        begin
            trap.active <= 1'b1;
            trap.code   <= fault_code;
            trap.epc    <= fault_pc;
        end
    end

    // flush leaves no younger fault behind the held one
    a_quiet_while_held: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        trap.active |-> fault_code == core_pkg::EXC_NONE)
        else $error("fault reached result while a trap is held");

endmodule

`default_nettype wire

// ==== hdl/core_top.sv ====
// ----------------------------------------------------------
// three stage integer core top; instructions come in on a
// strobed port and register writes leave on commit
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  wire logic                           SYS_clk,
    input  wire logic                           SYS_reset,
    input  wire logic                           load,
    input  wire logic [core_pkg::PC_W-1:0]      pc_value,
    input  wire logic                           instr_valid,
    input  wire logic [core_pkg::DATA_W-1:0]    instr,
    output core_pkg::commit_t                   commit,
    output core_pkg::trap_t                     trap
);

    core_pkg::decode_payload_t      dec_payload;
    core_pkg::execute_payload_t     ex_payload;
    core_pkg::execute_payload_t     ex_forward;
    logic [core_pkg::REG_ADDR_W-1:0] read_addr_a;
    logic [core_pkg::REG_ADDR_W-1:0] read_addr_b;
    logic [core_pkg::DATA_W-1:0]    read_data_a;
    logic [core_pkg::DATA_W-1:0]    read_data_b;
    logic [core_pkg::EXC_W-1:0]     fault_code;
    logic [core_pkg::PC_W-1:0]      fault_pc;
    logic                           flush;

    decode_stage u_decode (
        .SYS_clk     (SYS_clk),
        .SYS_reset   (SYS_reset),
        .load        (load),
        .pc_value    (pc_value),
        .instr_valid (instr_valid),
        .instr       (instr),
        .flush       (flush),
        .trap_active (trap.active),
        .read_addr_a (read_addr_a),
        .read_addr_b (read_addr_b),
        .read_data_a (read_data_a),
        .read_data_b (read_data_b),
        .ex_forward  (ex_forward),
        .commit      (commit),
        .payload     (dec_payload)
    );

    execute_stage u_execute (
        .SYS_clk     (SYS_clk),
        .SYS_reset   (SYS_reset),
        .flush       (flush),
        .in_payload  (dec_payload),
        .out_payload (ex_payload),
        .forward     (ex_forward)
    );

    result_stage u_result (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .in_payload (ex_payload),
        .commit     (commit),
        .fault_code (fault_code),
        .fault_pc   (fault_pc)
    );

    exception_unit u_exception (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .load       (load),
        .fault_code (fault_code),
        .fault_pc   (fault_pc),
        .flush      (flush),
        .trap       (trap)
    );

    register_file u_regs (
        .SYS_clk     (SYS_clk),
        .SYS_reset   (SYS_reset),
        .read_addr_a (read_addr_a),
        .read_addr_b (read_addr_b),
        .read_data_a (read_data_a),
        .read_data_b (read_data_b),
        .write       (commit)
    );

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
// ----------------------------------------------------------
// testbench clock (20 ns) and active high reset for 3 cycles
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic SYS_clk,
    output logic SYS_reset
);

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 3;

    initial
    begin
        SYS_clk   = 1'b0;
        SYS_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge SYS_clk);
        SYS_reset <= 1'b0;
    end

    always #(HALF_PERIOD) SYS_clk = ~SYS_clk;

endmodule

`default_nettype wire

// ==== verification/tb_core.sv ====
// ----------------------------------------------------------
// random instruction test of core_top against an in-order model
// faults are planted and cleared with load
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_core;

    localparam int PLANNED = 320;               // upper bound on issued words
    localparam int CYCLE_LIMIT = 4 * PLANNED + 200;

    logic                          SYS_clk;
    logic                          SYS_reset;
    logic                          load;
    logic [core_pkg::PC_W-1:0]     pc_value;
    logic                          instr_valid;
    logic [core_pkg::DATA_W-1:0]   instr;
    core_pkg::commit_t             commit;
    core_pkg::trap_t               trap;

    logic [31:0]         model_regs [32];
    logic [7:0]          model_pc;
    logic                model_halted;  // fault issued, waiting for load
    core_pkg::commit_t   exp_commits [$];
    int                  exp_due [$];
    core_pkg::trap_t     exp_trap;
    core_pkg::trap_t     pend_trap;
    logic                pend_valid;
    int                  pend_due;
    int                  cycle;
    int                  errors;

    tb_clock u_clock (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset)
    );

    core_top u_dut (
        .SYS_clk     (SYS_clk),
        .SYS_reset   (SYS_reset),
        .load        (load),
        .pc_value    (pc_value),
        .instr_valid (instr_valid),
        .instr       (instr),
        .commit      (commit),
        .trap        (trap)
    );

    task automatic check_commit(input core_pkg::commit_t got, input core_pkg::commit_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH at %0t: commit got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_trap(input core_pkg::trap_t got, input core_pkg::trap_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH at %0t: trap got %h expected %h", $time, got, exp);
        end
    endtask

    function automatic logic [31:0] rtype(input int rs, input int rt, input int rd,
                                          input int sh, input logic [5:0] fn);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic logic [31:0] addi(input int rt, input int rs, input logic [15:0] imm);
        return {6'h08, 5'(rs), 5'(rt), imm};
    endfunction

    // in-order reference step for one accepted word
    task automatic model_step(input logic [31:0] word);
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       res;
        logic [32:0]       wide;
        logic [2:0]        exc;
        logic [4:0]        dest;
        logic [7:0]        pc_this;
        logic              arith;
        core_pkg::commit_t entry;
        if (model_halted)
            return;
        pc_this = model_pc;
        model_pc = model_pc + 8'd1;
        if (word == 32'd0)
            return;             // bubble
        a = model_regs[word[25:21]];
        b = model_regs[word[20:16]];
        res = 32'd0;
        wide = 33'd0;
        exc = 3'd0;
        arith = 1'b0;
        dest = word[15:11];
        if (word[31:26] == 6'h08)
        begin
            dest = word[20:16];
            b = {{16{word[15]}}, word[15:0]};
            wide = {a[31], a} + {b[31], b};
            arith = 1'b1;
        end
        else if (word[31:26] != 6'h00)
            exc = 3'd1;
        else
        begin
            case (word[5:0])
                6'h20:
                begin
                    wide = {a[31], a} + {b[31], b};
                    arith = 1'b1;
                end
                6'h22:
                begin
                    wide = {a[31], a} - {b[31], b};
                    arith = 1'b1;
                end
                6'h24: wide = {1'b0, a & b};
                6'h25: wide = {1'b0, a | b};
                6'h2a: wide = {32'd0, $signed(a) < $signed(b)};
                6'h00: wide = {1'b0, b << word[10:6]};
                6'h02: wide = {1'b0, b >> word[10:6]};
                default: exc = 3'd1;
            endcase
        end
        res = wide[31:0];
        if (exc == 3'd0 && arith && wide[32] != wide[31])
            exc = 3'd2;         // signed overflow of add, sub and addi
        if (exc == 3'd0 && dest == 5'd0)
            exc = 3'd7;
        if (exc != 3'd0)
        begin
            model_halted = 1'b1;
            pend_trap = '{active: 1'b1, code: exc, epc: pc_this};
            pend_due = cycle + 4;
            pend_valid = 1'b1;
        end
        else
        begin
            model_regs[dest] = res;
            entry = '{valid: 1'b1, dest: dest, data: res};
            exp_commits.push_back(entry);
            exp_due.push_back(cycle + 3);
        end
    endtask

    task automatic issue(input logic [31:0] word);
        @(posedge SYS_clk);
        instr_valid <= 1'b1;
        instr <= word;
        model_step(word);
    endtask

    task automatic idle();
        @(posedge SYS_clk);
        instr_valid <= 1'b0;
        instr <= $urandom;      // must be ignored
    endtask

    task automatic random_block(input int count, input bit with_bubbles);
        logic [5:0] fns [7];
        int pick;
        fns = '{6'h20, 6'h22, 6'h24, 6'h25, 6'h2a, 6'h00, 6'h02};
        for (int i = 0; i < count; i++)
        begin
            pick = with_bubbles ? $urandom % 10 : 2 + $urandom % 8;
            if (pick == 0)
                idle();
            else if (pick == 1)
                issue(32'd0);
            else if (pick < 4)
                issue(addi(1 + $urandom % 6, 1 + $urandom % 6, 16'($urandom)));
            else
                issue(rtype(1 + $urandom % 6, 1 + $urandom % 6, 1 + $urandom % 6,
                            $urandom % 32, fns[$urandom % 7]));
        end
    endtask

    // wait for an expected trap, then clear it with a random pc
    task automatic recover();
        logic [7:0] v;
        if (!model_halted)
            return;
        idle();
        while (!exp_trap.active)
            @(posedge SYS_clk);
        v = 8'($urandom);
        @(posedge SYS_clk);
        load <= 1'b1;
        pc_value <= v;
        instr_valid <= 1'b1;
        instr <= $urandom;
        model_pc = v;
        model_halted = 1'b0;
        pend_trap = '0;
        pend_due = cycle + 1;
        pend_valid = 1'b1;
        @(posedge SYS_clk);
        load <= 1'b0;
        instr_valid <= 1'b0;
    endtask

    always @(negedge SYS_clk)
    begin
        if (!SYS_reset)
        begin
            if (pend_valid && cycle == pend_due)
            begin
                exp_trap = pend_trap;
                pend_valid = 1'b0;
            end
            check_trap(trap, exp_trap);
            if (commit.valid === 1'b1)
            begin
                if (exp_commits.size() == 0)
                begin
                    errors++;
                    $display("unexpected commit to r%0d at %0t", commit.dest, $time);
                end
                else
                begin
                    if (exp_due[0] != cycle)
                    begin
                        errors++;
                        $display("commit at cycle %0d, expected at cycle %0d", cycle, exp_due[0]);
                    end
                    check_commit(commit, exp_commits.pop_front());
                    void'(exp_due.pop_front());
                end
            end
            else if (exp_due.size() > 0 && exp_due[0] <= cycle)
            begin
                errors++;
                $display("expected commit to r%0d missing at %0t", exp_commits[0].dest, $time);
                void'(exp_commits.pop_front());
                void'(exp_due.pop_front());
            end
            cycle = cycle + 1;
            if (cycle > CYCLE_LIMIT)
            begin
                $display("timeout after %0d cycles", cycle);
                $display("SIMULATION FAILED");
                $finish;
            end
        end
    end

    initial
    begin
        void'($urandom(32'h03b12725));
        load = 1'b0;
        pc_value = '0;
        instr_valid = 1'b0;
        instr = '0;
        model_pc = 8'd0;
        model_halted = 1'b0;
        exp_trap = '0;
        pend_trap = '0;
        pend_valid = 1'b0;
        pend_due = 0;
        cycle = 0;
        errors = 0;
        for (int r = 0; r < 32; r++)
            model_regs[r] = 32'd0;
        @(negedge SYS_reset);
        repeat (4) idle();      // nothing may commit yet
        for (int r = 1; r < 32; r++)
            issue(addi(r, 0, 16'($urandom)));
        random_block(120, 1'b1);
        recover();
        issue(addi(1, 0, 16'd1));
        issue(rtype(0, 1, 1, 30, 6'h00));   // r1 = 0x40000000
        issue(rtype(1, 1, 2, 0, 6'h20));    // add overflows
        random_block(3, 1'b0);
        recover();
        issue(addi(1, 0, 16'd1));
        issue(rtype(0, 1, 3, 31, 6'h00));   // r3 = 0x80000000
        issue(rtype(0, 1, 1, 30, 6'h00));
        issue(rtype(1, 3, 4, 0, 6'h22));    // sub overflows
        recover();
        issue(addi(5, 0, 16'hffff));
        issue(rtype(0, 5, 5, 1, 6'h02));    // r5 = 0x7fffffff
        issue(addi(6, 5, 16'd1));
        recover();
        random_block(10, 1'b0);
        issue({6'h3f, 26'($urandom)});      // undefined opcode
        recover();
        random_block(10, 1'b0);
        issue(rtype(1, 2, 3, 0, 6'h3b));    // undefined funct
        recover();
        random_block(10, 1'b1);
        issue(rtype(1, 2, 0, 0, 6'h25));    // write to r0
        recover();
        random_block(10, 1'b1);
        issue(addi(0, 3, 16'h0042));
        recover();
        random_block(8, 1'b1);
        repeat (10) idle();
        if (exp_commits.size() != 0)
        begin
            errors++;
            $display("%0d expected commits never arrived", exp_commits.size());
        end
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/core_pkg.sv
hdl/register_file.sv
hdl/alu.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/exception_unit.sv
hdl/core_top.sv
verification/tb_clock.sv
verification/tb_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator, run, and judge the run from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -f build.f --top-module tb_core \
    -o sim_core > build.log 2>&1 \
    && ./obj_dir/sim_core > sim.log 2>&1 \
    || { echo "build or run error, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0
